// File: logic/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	// ------------------------------------------------------------
	// bus widths
	// ------------------------------------------------------------
	parameter int WORD_W = 32;
	parameter int SEL_W = WORD_W / 8;	// byte lanes
	parameter int IMM_W = 24;

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [3:0] reg_idx_t;

	// ------------------------------------------------------------
	// instruction encoding
	// ------------------------------------------------------------
	// codes 14 and 15 are unlisted and run as NOP
	typedef enum logic [3:0] {
		NOP  = 4'h0,
		ADD  = 4'h1,
		SUB  = 4'h2,
		AND  = 4'h3,
		OR   = 4'h4,
		XOR  = 4'h5,
		LDI  = 4'h6,
		LD   = 4'h7,
		ST   = 4'h8,
		BEQ  = 4'h9,
		BNE  = 4'ha,
		BCS  = 4'hb,
		BRA  = 4'hc,
		HALT = 4'hd
	} opcode_e;

	typedef struct packed {
		opcode_e op;
		reg_idx_t rt;	// target
		reg_idx_t ra;
		reg_idx_t rb;
		logic [15:0] unused;
	} insn_reg_t;

	typedef struct packed {
		opcode_e op;
		reg_idx_t rt;
		logic [IMM_W-1:0] imm;	// branch offset in words, or data
	} insn_imm_t;

	// same word seen as register form or immediate form
	typedef union packed {
		insn_reg_t r;
		insn_imm_t i;
	} insn_u;

	// ------------------------------------------------------------
	// execution
	// ------------------------------------------------------------
	typedef struct packed {
		logic zero;
		logic carry;
		logic negative;
	} flags_t;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_PASS_B
	} alu_op_e;

	localparam word_t NOP_WORD = '0;

endpackage

`default_nettype wire

// File: logic/fetch_unit.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_unit import cpu_pkg::*; #(
	parameter logic [31:0] RESET_PC = 32'h0
) (
	input  logic    clk,
	input  logic    rst_i,
	input  logic    take_i,
	input  logic    redirect_i,
	input  word_t   target_i,
	input  logic    halt_i,
	input  logic    f_ack_i,
	input  word_t   f_dat_i,
	output logic    f_req_o,
	output word_t   f_adr_o,
	output logic    insn_valid_o,
	output insn_u   insn_o,
	output word_t   pc_o
);

	word_t pc_q;
	word_t req_adr_q;
	word_t buf_word_q;
	word_t buf_tag_q;	// address the buffered word came from
	logic buf_full_q;
	logic req_q;
	logic drop_q;		// in-flight word is stale after a redirect
	logic buf_hit;
	logic start_fetch;
	logic fill;

	assign buf_hit = buf_full_q && (buf_tag_q == pc_q);
	assign start_fetch = !req_q && !buf_hit && !halt_i && !redirect_i;
	assign fill = req_q && f_ack_i && !drop_q && !redirect_i;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			pc_q <= RESET_PC;
			buf_full_q <= 1'b0;
			req_q <= 1'b0;
			drop_q <= 1'b0;
			buf_word_q <= NOP_WORD;
		end else begin
			if (redirect_i)
				pc_q <= target_i;
			else if (take_i)
				pc_q <= pc_q + 32'd4;	// word consumed, buffer tag now stale

			if (req_q && f_ack_i) begin
				req_q <= 1'b0;
				drop_q <= 1'b0;
			end else if (start_fetch) begin
				req_q <= 1'b1;
			end
			if (redirect_i && req_q && !f_ack_i)
				drop_q <= 1'b1;	// let the bus cycle finish, discard its word

			if (redirect_i)
				buf_full_q <= 1'b0;
			else if (fill) begin
				buf_full_q <= 1'b1;
				buf_word_q <= f_dat_i;
			end
		end
	end

	// address and tag travel with the request
	always_ff @(posedge clk) begin
		if (start_fetch)
			req_adr_q <= pc_q;
		if (fill)
			buf_tag_q <= req_adr_q;
	end

	assign f_req_o = req_q;
	assign f_adr_o = req_adr_q;
	assign insn_valid_o = buf_hit;
	assign insn_o = buf_word_q;
	assign pc_o = pc_q;

endmodule

`default_nettype wire

// File: logic/load_store_unit.sv
`timescale 1ns/1ns
`default_nettype none

module load_store_unit import cpu_pkg::*; (
	input  logic    clk,
	input  logic    rst_i,
	input  logic    start_i,
	input  logic    write_i,
	input  word_t   addr_i,
	input  word_t   wdata_i,
	input  logic    d_ack_i,
	input  word_t   d_dat_i,
	output logic    d_req_o,
	output logic    d_we_o,
	output word_t   d_adr_o,
	output word_t   d_dat_o,
	output logic    done_o,
	output word_t   rdata_o
);

	logic req_q;
	logic write_q;
	logic done_q;
	word_t addr_q;
	word_t wdata_q;
	word_t rdata_q;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			req_q <= 1'b0;
			write_q <= 1'b0;
			done_q <= 1'b0;
		end else begin
			done_q <= 1'b0;		// single-cycle pulse
			if (start_i) begin
				req_q <= 1'b1;
				write_q <= write_i;
			end else if (req_q && d_ack_i) begin
				req_q <= 1'b0;
				done_q <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start_i) begin
			addr_q <= addr_i;
			wdata_q <= wdata_i;
		end
		if (req_q && d_ack_i)
			rdata_q <= d_dat_i;	// dat_i only valid with ack
	end

	assign d_req_o = req_q;
	assign d_we_o = write_q;
	assign d_adr_o = addr_q;
	assign d_dat_o = wdata_q;
	assign done_o = done_q;
	assign rdata_o = rdata_q;

endmodule

`default_nettype wire

// File: logic/bus_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module bus_arbiter import cpu_pkg::*; (
	input  logic             clk,
	input  logic             rst_i,
	input  logic             f_req_i,
	input  word_t            f_adr_i,
	input  logic             d_req_i,
	input  logic             d_we_i,
	input  word_t            d_adr_i,
	input  word_t            d_dat_i,
	input  logic             ack_i,
	input  word_t            dat_i,
	output logic             f_ack_o,
	output logic             d_ack_o,
	output word_t            f_dat_o,
	output word_t            d_dat_o,
	output logic             cyc_o,
	output logic             stb_o,
	output logic             we_o,
	output logic [SEL_W-1:0] sel_o,
	output word_t            adr_o,
	output word_t            dat_o
);

	localparam logic OWN_FETCH = 1'b0;
	localparam logic OWN_DATA = 1'b1;

	logic owner_q;
	logic busy_q;
	logic own_data;

	// ------------------------------------------------------------
	// grant, only while idle; data side wins
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst_i) begin
			owner_q <= OWN_FETCH;
			busy_q <= 1'b0;
		end else if (!busy_q) begin
			if (d_req_i) begin
				owner_q <= OWN_DATA;
				busy_q <= 1'b1;
			end else if (f_req_i) begin
				owner_q <= OWN_FETCH;
				busy_q <= 1'b1;
			end
		end else if (ack_i) begin
			busy_q <= 1'b0;	// grant held up to the owner's ack
		end
	end

	assign own_data = owner_q == OWN_DATA;

	// ------------------------------------------------------------
	// bus side
	// ------------------------------------------------------------
	assign cyc_o = busy_q;
	assign stb_o = busy_q;
	assign we_o = busy_q && own_data && d_we_i;
	assign sel_o = '1;		// whole words only
	assign adr_o = own_data ? d_adr_i : f_adr_i;
	assign dat_o = d_dat_i;

	// ack goes to the owner alone
	assign f_ack_o = busy_q && ack_i && !own_data;
	assign d_ack_o = busy_q && ack_i && own_data;
	assign f_dat_o = dat_i;
	assign d_dat_o = dat_i;

endmodule

`default_nettype wire

// File: logic/reg_file.sv
`timescale 1ns/1ns
`default_nettype none

module reg_file import cpu_pkg::*; (
	input  logic     clk,
	input  logic     we_i,
	input  reg_idx_t wa_i,
	input  word_t    wd_i,
	input  reg_idx_t ra_i,
	input  reg_idx_t rb_i,
	output word_t    qa_o,
	output word_t    qb_o
);

	word_t regs [16];

	always_ff @(posedge clk) begin
		if (we_i && wa_i != 4'd0)
			regs[wa_i] <= wd_i;
	end

	// r0 reads as zero
	assign qa_o = (ra_i == 4'd0) ? '0 : regs[ra_i];
	assign qb_o = (rb_i == 4'd0) ? '0 : regs[rb_i];

endmodule

`default_nettype wire

// File: logic/alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu import cpu_pkg::*; (
	input  alu_op_e op_i,
	input  word_t   a_i,
	input  word_t   b_i,
	output word_t   y_o,
	output flags_t  flags_o
);

	logic [WORD_W:0] sum;
	logic [WORD_W:0] diff;

	assign sum = {1'b0, a_i} + {1'b0, b_i};
	assign diff = {1'b0, a_i} - {1'b0, b_i};	// top bit set on borrow

	always_comb begin
		y_o = b_i;
		flags_o.carry = 1'b0;	// cleared by logic ops
		case (op_i)
			ALU_ADD: begin
				y_o = sum[WORD_W-1:0];
				flags_o.carry = sum[WORD_W];
			end
			ALU_SUB: begin
				y_o = diff[WORD_W-1:0];
				flags_o.carry = !diff[WORD_W];	// a >= b unsigned
			end
			ALU_AND: y_o = a_i & b_i;
			ALU_OR:  y_o = a_i | b_i;
			ALU_XOR: y_o = a_i ^ b_i;
			default: y_o = b_i;
		endcase
		flags_o.zero = (y_o == '0);
		flags_o.negative = y_o[WORD_W-1];
	end

endmodule

`default_nettype wire

// File: logic/cpu_control.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_control import cpu_pkg::*; (
	input  logic     clk,
	input  logic     rst_i,
	input  logic     insn_valid_i,
	input  insn_u    insn_i,
	input  word_t    pc_i,
	input  word_t    qa_i,
	input  word_t    qb_i,
	input  word_t    alu_y_i,
	input  flags_t   alu_flags_i,
	input  logic     ls_done_i,
	input  word_t    ls_rdata_i,
	output logic     take_o,
	output logic     redirect_o,
	output word_t    target_o,
	output logic     halt_o,
	output logic     ls_start_o,
	output logic     ls_write_o,
	output word_t    ls_addr_o,
	output word_t    ls_wdata_o,
	output reg_idx_t ra_o,
	output reg_idx_t rb_o,
	output alu_op_e  alu_op_o,
	output logic     rf_we_o,
	output reg_idx_t rf_wa_o,
	output word_t    rf_wd_o,
	output logic     halted_o
);

	localparam logic [1:0] S_IDLE = 2'd0;
	localparam logic [1:0] S_EXEC = 2'd1;
	localparam logic [1:0] S_MEM = 2'd2;
	localparam logic [1:0] S_HALT = 2'd3;

	logic [1:0] state_q;
	insn_u ir_q;
	word_t ex_pc_q;		// address of the executing word
	flags_t flags_q;
	opcode_e op;
	logic is_alu;
	logic is_mem;
	logic taken;
	word_t imm_sext;
	word_t imm_zext;

	assign op = ir_q.r.op;
	assign imm_sext = {{(WORD_W-IMM_W){ir_q.i.imm[IMM_W-1]}}, ir_q.i.imm};
	assign imm_zext = {{(WORD_W-IMM_W){1'b0}}, ir_q.i.imm};
	assign is_mem = (op == LD) || (op == ST);

	// ------------------------------------------------------------
	// decode and branch evaluation
	// ------------------------------------------------------------
	always_comb begin
		is_alu = 1'b0;
		alu_op_o = ALU_PASS_B;
		taken = 1'b0;
		case (op)
			ADD: begin is_alu = 1'b1; alu_op_o = ALU_ADD; end
			SUB: begin is_alu = 1'b1; alu_op_o = ALU_SUB; end
			AND: begin is_alu = 1'b1; alu_op_o = ALU_AND; end
			OR:  begin is_alu = 1'b1; alu_op_o = ALU_OR; end
			XOR: begin is_alu = 1'b1; alu_op_o = ALU_XOR; end
			BEQ: taken = flags_q.zero;
			BNE: taken = !flags_q.zero;
			BCS: taken = flags_q.carry;
			BRA: taken = 1'b1;
			default: ;	// NOP and unlisted codes
		endcase
	end

	// ------------------------------------------------------------
	// sequencer
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst_i) begin
			state_q <= S_IDLE;
			flags_q <= '0;
		end else begin
			case (state_q)
				S_IDLE: if (insn_valid_i) state_q <= S_EXEC;
				S_EXEC: begin
					if (is_alu)
						flags_q <= alu_flags_i;
					if (op == HALT)
						state_q <= S_HALT;
					else if (is_mem)
						state_q <= S_MEM;
					else
						state_q <= S_IDLE;
				end
				S_MEM: if (ls_done_i) state_q <= S_IDLE;
				default: state_q <= S_HALT;	// stays halted until reset
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (take_o) begin
			ir_q <= insn_i;
			ex_pc_q <= pc_i;
		end
	end

	assign take_o = (state_q == S_IDLE) && insn_valid_i;
	assign redirect_o = (state_q == S_EXEC) && taken;
	assign target_o = ex_pc_q + 32'd4 + {imm_sext[WORD_W-3:0], 2'b00};
	// stop fetch already while HALT executes
	assign halt_o = (state_q == S_HALT) || ((state_q == S_EXEC) && (op == HALT));
	assign halted_o = state_q == S_HALT;

	assign ls_start_o = (state_q == S_EXEC) && is_mem;
	assign ls_write_o = op == ST;
	assign ls_addr_o = imm_zext;	// absolute byte address
	assign ls_wdata_o = qb_i;

	assign ra_o = ir_q.r.ra;
	assign rb_o = (op == ST) ? ir_q.r.rt : ir_q.r.rb;	// store data via port b
	assign rf_wa_o = ir_q.r.rt;

	// write-back select
	always_comb begin
		if (state_q == S_MEM) begin
			rf_we_o = ls_done_i && (op == LD);
			rf_wd_o = ls_rdata_i;
		end else begin
			rf_we_o = (state_q == S_EXEC) && (is_alu || op == LDI);
			if (is_alu)
				rf_wd_o = alu_y_i;
			else if (op == LDI)
				rf_wd_o = imm_sext;
			else
				rf_wd_o = qa_i;		// register copy, no write enabled
		end
	end

endmodule

`default_nettype wire

// File: logic/cpu_top.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_top import cpu_pkg::*; #(
	parameter logic [31:0] RESET_PC = 32'h0
) (
	input  logic             clk,
	input  logic             rst_i,
	input  word_t            dat_i,
	input  logic             ack_i,
	output logic             cyc_o,
	output logic             stb_o,
	output logic             we_o,
	output logic [SEL_W-1:0] sel_o,
	output word_t            adr_o,
	output word_t            dat_o,
	output logic             halted_o
);

	// fetch side
	logic f_req, f_ack;
	word_t f_adr, f_dat;
	logic take, redirect, halt, insn_valid;
	word_t target, pc;
	insn_u insn;

	// data side
	logic d_req, d_we, d_ack;
	word_t d_adr, d_wdat, d_rdat;
	logic ls_start, ls_write, ls_done;
	word_t ls_addr, ls_wdata, ls_rdata;

	// execute
	reg_idx_t ra, rb, rf_wa;
	word_t qa, qb, rf_wd, alu_y;
	logic rf_we;
	alu_op_e alu_op;
	flags_t alu_flags;

	fetch_unit #(.RESET_PC(RESET_PC)) u_fetch (
		.clk(clk), .rst_i(rst_i), .take_i(take), .redirect_i(redirect),
		.target_i(target), .halt_i(halt), .f_ack_i(f_ack), .f_dat_i(f_dat),
		.f_req_o(f_req), .f_adr_o(f_adr), .insn_valid_o(insn_valid),
		.insn_o(insn), .pc_o(pc)
	);

	load_store_unit u_lsu (
		.clk(clk), .rst_i(rst_i), .start_i(ls_start), .write_i(ls_write),
		.addr_i(ls_addr), .wdata_i(ls_wdata), .d_ack_i(d_ack), .d_dat_i(d_rdat),
		.d_req_o(d_req), .d_we_o(d_we), .d_adr_o(d_adr), .d_dat_o(d_wdat),
		.done_o(ls_done), .rdata_o(ls_rdata)
	);

	bus_arbiter u_arb (
		.clk(clk), .rst_i(rst_i), .f_req_i(f_req), .f_adr_i(f_adr),
		.d_req_i(d_req), .d_we_i(d_we), .d_adr_i(d_adr), .d_dat_i(d_wdat),
		.ack_i(ack_i), .dat_i(dat_i), .f_ack_o(f_ack), .d_ack_o(d_ack),
		.f_dat_o(f_dat), .d_dat_o(d_rdat), .cyc_o(cyc_o), .stb_o(stb_o),
		.we_o(we_o), .sel_o(sel_o), .adr_o(adr_o), .dat_o(dat_o)
	);

	reg_file u_rf (
		.clk(clk), .we_i(rf_we), .wa_i(rf_wa), .wd_i(rf_wd),
		.ra_i(ra), .rb_i(rb), .qa_o(qa), .qb_o(qb)
	);

	alu u_alu (
		.op_i(alu_op), .a_i(qa), .b_i(qb), .y_o(alu_y), .flags_o(alu_flags)
	);

	cpu_control u_ctrl (
		.clk(clk), .rst_i(rst_i), .insn_valid_i(insn_valid), .insn_i(insn),
		.pc_i(pc), .qa_i(qa), .qb_i(qb), .alu_y_i(alu_y), .alu_flags_i(alu_flags),
		.ls_done_i(ls_done), .ls_rdata_i(ls_rdata), .take_o(take),
		.redirect_o(redirect), .target_o(target), .halt_o(halt),
		.ls_start_o(ls_start), .ls_write_o(ls_write), .ls_addr_o(ls_addr),
		.ls_wdata_o(ls_wdata), .ra_o(ra), .rb_o(rb), .alu_op_o(alu_op),
		.rf_we_o(rf_we), .rf_wa_o(rf_wa), .rf_wd_o(rf_wd), .halted_o(halted_o)
	);

endmodule

`default_nettype wire

// File: testbench/cpu_properties.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_properties import cpu_pkg::*; (
	input logic  clk,
	input logic  rst_i,
	input logic  f_req_i,
	input logic  d_req_i,
	input logic  cyc_o,
	input logic  stb_o,
	input logic  we_o,
	input logic  ack_i,
	input word_t adr_o,
	input logic  own_data
);

	int fail_count = 0;

	// ------------------------------------------------------------
	// bus protocol
	// ------------------------------------------------------------
	// a strobe needs the cycle and a request held by the owner
	stb_has_cyc: assert property (@(posedge clk) disable iff (rst_i)
		stb_o |-> (cyc_o && (own_data ? d_req_i : f_req_i)))
		else begin
			$error("stb_o high without cyc_o or without a request from the owner");
			fail_count++;
		end

	// address held until the slave answers
	adr_held: assert property (@(posedge clk) disable iff (rst_i)
		(stb_o && !ack_i) |=> $stable(adr_o))
		else begin
			$error("adr_o changed during a bus cycle");
			fail_count++;
		end

	write_by_data: assert property (@(posedge clk) disable iff (rst_i)
		we_o |-> (own_data && d_req_i))
		else begin
			$error("we_o high while the data side does not own the bus");
			fail_count++;
		end

endmodule

bind bus_arbiter cpu_properties props0 (
	.clk(clk), .rst_i(rst_i), .f_req_i(f_req_i), .d_req_i(d_req_i),
	.cyc_o(cyc_o), .stb_o(stb_o), .we_o(we_o),
	.ack_i(ack_i), .adr_o(adr_o), .own_data(own_data)
);

`default_nettype wire

// File: testbench/tb_cpu.sv
`timescale 1ns/1ns
`default_nettype none

module tb_cpu import cpu_pkg::*; ();

	localparam int MEM_WORDS = 1024;
	localparam int PROG_WORDS = 256;	// words below this hold code, the rest is data
	localparam int HALT_TIMEOUT = 4000;

	logic clk;
	logic rst_i;
	logic ack_i;
	word_t dat_i;
	logic cyc_o, stb_o, we_o, halted_o;
	logic [SEL_W-1:0] sel_o;
	word_t adr_o, dat_o;

	word_t mem [MEM_WORDS];
	word_t prog [32];
	int prog_len;
	word_t wr_adr_q [$];	// write record
	word_t wr_dat_q [$];
	int cycle_count;	// bus cycles started since reset
	int wait_left;
	logic in_cycle;
	logic rst_seen;
	int errors;
	int checks;
	int tests_run;

	cpu_top #(.RESET_PC(32'h0)) dut0 (
		.clk(clk), .rst_i(rst_i), .dat_i(dat_i), .ack_i(ack_i), .cyc_o(cyc_o),
		.stb_o(stb_o), .we_o(we_o), .sel_o(sel_o), .adr_o(adr_o), .dat_o(dat_o),
		.halted_o(halted_o)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ------------------------------------------------------------
	// checks
	// ------------------------------------------------------------
	task automatic check_word(input string what, input word_t got, input word_t exp);
		checks++;
		if (got !== exp) begin
			$display("MISMATCH at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_flag(input string what, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			$display("MISMATCH at %0t ns: %s, got %b, expected %b", $time, what, got, exp);
			errors++;
		end
	endtask

	// ------------------------------------------------------------
	// memory slave with random wait states
	// ------------------------------------------------------------
	always begin
		@(posedge clk);
		rst_seen = rst_i;
		#5;
		if (rst_seen) begin
			ack_i = 1'b0;
			in_cycle = 1'b0;
		end else if (ack_i) begin
			ack_i = 1'b0;	// one-cycle pulse
		end else if (cyc_o && stb_o) begin
			if (!in_cycle) begin
				in_cycle = 1'b1;
				wait_left = $urandom % 4;
				cycle_count++;
			end
			if (wait_left == 0) begin
				check_flag("sel_o all lanes", &sel_o, 1'b1);
				check_flag("adr_o word aligned", adr_o[1:0] == 2'b00, 1'b1);
				if (we_o) begin
					mem[adr_o[11:2]] = dat_o;
					wr_adr_q.push_back(adr_o);
					wr_dat_q.push_back(dat_o);
				end else begin
					dat_i = mem[adr_o[11:2]];
				end
				ack_i = 1'b1;
				in_cycle = 1'b0;
			end else begin
				wait_left--;
			end
		end
	end

	// ------------------------------------------------------------
	// program building and memory helpers
	// ------------------------------------------------------------
	function automatic word_t reg_insn(input opcode_e op, input reg_idx_t rt,
			input reg_idx_t ra, input reg_idx_t rb);
		insn_u u;
		u = NOP_WORD;
		u.r.op = op;
		u.r.rt = rt;
		u.r.ra = ra;
		u.r.rb = rb;
		return u;
	endfunction

	function automatic word_t imm_insn(input opcode_e op, input reg_idx_t rt,
			input logic [IMM_W-1:0] imm);
		insn_u u;
		u = NOP_WORD;
		u.i.op = op;
		u.i.rt = rt;
		u.i.imm = imm;
		return u;
	endfunction

	// unique per word index so a wrong address shows up
	function automatic word_t fill_word(input int idx);
		return 32'hd000_0000 ^ (word_t'(idx) << 2) ^ (word_t'(idx) << 18);
	endfunction

	function automatic word_t mem_at(input word_t adr);
		return mem[adr[11:2]];
	endfunction

	function automatic bit was_written(input word_t adr);
		foreach (wr_adr_q[k]) begin
			if (wr_adr_q[k] == adr)
				return 1'b1;
		end
		return 1'b0;
	endfunction

	task automatic add_insn(input word_t w);
		prog[prog_len] = w;
		prog_len++;
	endtask

	// holds reset while the memory is refilled
	task automatic load_and_reset();
		rst_i = 1'b1;
		for (int i = 0; i < MEM_WORDS; i++)
			mem[i] = (i < PROG_WORDS) ? NOP_WORD : fill_word(i);
		for (int i = 0; i < prog_len; i++)
			mem[i] = prog[i];
		wr_adr_q.delete();
		wr_dat_q.delete();
		cycle_count = 0;
	endtask

	task automatic run_to_halt();
		int n;
		repeat (5) begin
			@(posedge clk);
			#5;
		end
		check_flag("cyc_o in reset", cyc_o, 1'b0);
		check_flag("stb_o in reset", stb_o, 1'b0);
		check_flag("we_o in reset", we_o, 1'b0);
		check_flag("halted_o in reset", halted_o, 1'b0);
		rst_i = 1'b0;
		n = 0;
		while (!halted_o && n < HALT_TIMEOUT) begin
			@(posedge clk);
			#5;
			n++;
		end
		if (!halted_o) begin
			$display("ERROR at %0t ns: core did not halt within %0d cycles", $time, HALT_TIMEOUT);
			errors++;
		end
	endtask

	task automatic finish_test(input string name, input int err_start);
		tests_run++;
		$display("%s: %s", name, (errors == err_start) ? "ok" : "errors found");
	endtask

	// ------------------------------------------------------------
	// directed tests
	// ------------------------------------------------------------
	task automatic ldi_and_store();
		int err_start;
		err_start = errors;
		prog_len = 0;
		add_insn(imm_insn(LDI, 4'd1, 24'hfffffb));
		add_insn(imm_insn(LDI, 4'd2, 24'h123456));
		add_insn(imm_insn(LDI, 4'd3, 24'h800000));
		add_insn(imm_insn(ST, 4'd1, 24'h000400));
		add_insn(imm_insn(ST, 4'd2, 24'h000404));
		add_insn(imm_insn(ST, 4'd3, 24'h000408));
		add_insn(imm_insn(ST, 4'd0, 24'h00040c));	// r0 reads as zero
		add_insn(imm_insn(HALT, 4'd0, 24'h0));
		load_and_reset();
		run_to_halt();
		check_word("ldi -5", mem_at(32'h400), 32'hffff_fffb);
		check_word("ldi positive", mem_at(32'h404), 32'h0012_3456);
		check_word("ldi top bit", mem_at(32'h408), 32'hff80_0000);
		check_word("store r0", mem_at(32'h40c), 32'h0);
		check_word("write count", word_t'(wr_adr_q.size()), 32'd4);
		finish_test("ldi_and_store", err_start);
	endtask

	task automatic alu_operations();
		int err_start;
		word_t a;
		word_t b;
		err_start = errors;
		a = 32'hffff_0f00;
		b = 32'h0012_3456;
		prog_len = 0;
		add_insn(imm_insn(LDI, 4'd1, 24'hff0f00));
		add_insn(imm_insn(LDI, 4'd2, 24'h123456));
		add_insn(reg_insn(ADD, 4'd3, 4'd1, 4'd2));
		add_insn(imm_insn(BCS, 4'd0, 24'd1));		// add carries out so the next store is skipped
		add_insn(imm_insn(ST, 4'd1, 24'h000518));
		add_insn(reg_insn(SUB, 4'd4, 4'd1, 4'd2));
		add_insn(reg_insn(AND, 4'd5, 4'd1, 4'd2));
		add_insn(reg_insn(OR, 4'd6, 4'd1, 4'd2));
		add_insn(reg_insn(XOR, 4'd7, 4'd1, 4'd2));
		add_insn(reg_insn(SUB, 4'd8, 4'd2, 4'd1));	// wraps below zero
		for (int r = 3; r <= 8; r++)
			add_insn(imm_insn(ST, reg_idx_t'(r), 24'h000500 + 24'((r - 3) * 4)));
		add_insn(imm_insn(HALT, 4'd0, 24'h0));
		load_and_reset();
		run_to_halt();
		check_word("add", mem_at(32'h500), a + b);
		check_word("sub", mem_at(32'h504), a - b);
		check_word("and", mem_at(32'h508), a & b);
		check_word("or", mem_at(32'h50c), a | b);
		check_word("xor", mem_at(32'h510), a ^ b);
		check_word("sub wrap", mem_at(32'h514), b - a);
		check_flag("store after add carry skipped", was_written(32'h518), 1'b0);
		finish_test("alu_operations", err_start);
	endtask

	task automatic load_and_add();
		int err_start;
		err_start = errors;
		prog_len = 0;
		add_insn(imm_insn(LD, 4'd1, 24'h000600));
		add_insn(imm_insn(LD, 4'd2, 24'h000604));	// untouched fill word
		add_insn(reg_insn(ADD, 4'd3, 4'd1, 4'd2));
		add_insn(imm_insn(ST, 4'd3, 24'h000608));
		add_insn(imm_insn(ST, 4'd1, 24'h00060c));
		add_insn(imm_insn(HALT, 4'd0, 24'h0));
		load_and_reset();
		mem[32'h600 >> 2] = 32'h1357_9bdf;
		run_to_halt();
		check_word("loaded word", mem_at(32'h60c), 32'h1357_9bdf);
		check_word("load sum", mem_at(32'h608), 32'h1357_9bdf + fill_word(32'h604 >> 2));
		check_word("write count", word_t'(wr_adr_q.size()), 32'd2);
		finish_test("load_and_add", err_start);
	endtask

	task automatic branch_paths();
		int err_start;
		err_start = errors;
		prog_len = 0;
		add_insn(imm_insn(LDI, 4'd1, 24'd5));
		add_insn(imm_insn(LDI, 4'd2, 24'd5));
		add_insn(imm_insn(LDI, 4'd3, 24'd7));
		add_insn(imm_insn(LDI, 4'd9, 24'h11));
		add_insn(reg_insn(SUB, 4'd4, 4'd1, 4'd2));	// equal
		add_insn(imm_insn(BEQ, 4'd0, 24'd1));		// taken
		add_insn(imm_insn(ST, 4'd9, 24'h000700));
		add_insn(reg_insn(SUB, 4'd4, 4'd1, 4'd3));	// 5 - 7 borrows
		add_insn(imm_insn(BEQ, 4'd0, 24'd1));		// not taken
		add_insn(imm_insn(ST, 4'd9, 24'h000704));
		add_insn(imm_insn(BCS, 4'd0, 24'd1));		// not taken
		add_insn(imm_insn(ST, 4'd9, 24'h000708));
		add_insn(reg_insn(SUB, 4'd4, 4'd3, 4'd1));	// 7 - 5 does not borrow
		add_insn(imm_insn(BCS, 4'd0, 24'd1));		// taken
		add_insn(imm_insn(ST, 4'd9, 24'h00070c));
		add_insn(imm_insn(BRA, 4'd0, 24'd1));
		add_insn(imm_insn(ST, 4'd9, 24'h000710));
		add_insn(imm_insn(ST, 4'd1, 24'h000714));
		add_insn(imm_insn(HALT, 4'd0, 24'h0));
		load_and_reset();
		run_to_halt();
		check_word("write count", word_t'(wr_adr_q.size()), 32'd3);
		check_flag("beq taken skips", was_written(32'h700), 1'b0);
		check_flag("bcs taken skips", was_written(32'h70c), 1'b0);
		check_flag("bra skips", was_written(32'h710), 1'b0);
		check_word("skipped word kept", mem_at(32'h700), fill_word(32'h700 >> 2));
		check_word("beq not taken", mem_at(32'h704), 32'h11);
		check_word("bcs not taken", mem_at(32'h708), 32'h11);
		check_word("after bra", mem_at(32'h714), 32'd5);
		finish_test("branch_paths", err_start);
	endtask

	task automatic halt_behavior();
		int err_start;
		int cycles_at_halt;
		err_start = errors;
		prog_len = 0;
		add_insn(imm_insn(LDI, 4'd1, 24'h42));
		add_insn(imm_insn(ST, 4'd1, 24'h000800));
		add_insn(imm_insn(NOP, 4'd0, 24'h0));
		add_insn(imm_insn(HALT, 4'd0, 24'h0));
		add_insn(imm_insn(ST, 4'd1, 24'h000804));	// never runs
		load_and_reset();
		run_to_halt();
		check_flag("halted_o", halted_o, 1'b1);
		cycles_at_halt = cycle_count;
		repeat (50) begin
			@(posedge clk);
			#5;
		end
		check_word("bus cycles after halt", word_t'(cycle_count), word_t'(cycles_at_halt));
		check_flag("halted_o held", halted_o, 1'b1);
		check_flag("cyc_o idle", cyc_o, 1'b0);
		check_word("write count", word_t'(wr_adr_q.size()), 32'd1);
		foreach (wr_adr_q[k]) begin
			check_word("write address", wr_adr_q[k], 32'h800);
			check_word("write data", wr_dat_q[k], 32'h42);
		end
		check_word("stored before halt", mem_at(32'h800), 32'h42);
		finish_test("halt_behavior", err_start);
	endtask

	// ------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------
	initial begin
		rst_i = 1'b1;
		ack_i = 1'b0;
		dat_i = '0;
		errors = 0;
		checks = 0;
		tests_run = 0;
		prog_len = 0;
		cycle_count = 0;
		wait_left = 0;
		in_cycle = 1'b0;
		void'($urandom(32'h4a33));
		ldi_and_store();
		alu_operations();
		load_and_add();
		branch_paths();
		halt_behavior();
		if (dut0.u_arb.props0.fail_count != 0) begin
			$display("bus protocol assertions failed %0d times", dut0.u_arb.props0.fail_count);
			errors += dut0.u_arb.props0.fail_count;
		end
		$display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
		if (errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: files.f
logic/cpu_pkg.sv
logic/fetch_unit.sv
logic/load_store_unit.sv
logic/bus_arbiter.sv
logic/reg_file.sv
logic/alu.sv
logic/cpu_control.sv
logic/cpu_top.sv
testbench/cpu_properties.sv
testbench/tb_cpu.sv
